/* sources.f */
+incdir+src
src/tile_mem_pkg.sv
src/sram_if.sv
src/bram_block.sv
src/sram_sp_banked.sv
src/sram_bus_adapter.sv
src/tile_mem.sv
tests/tile_mem_tb.sv

/* tests/tile_mem_tb.sv */
// Tile memory testbench
`timescale 1ns/100ps
`include "tile_mem_defs.svh"

module tile_mem_tb;

   localparam int RESET_CYCLES = 10;
   localparam int ACK_LIMIT = 20;
   localparam int N_RANDOM = 300;
   // Boundary test 16, lane test 16, rdata hold test 4, then the random run
   localparam int N_TXN = 16 + 16 + 4 + N_RANDOM;
   localparam int WATCHDOG_CYCLES = N_TXN * 12 + RESET_CYCLES + 200;

   // One finished handshake as seen on the bus
   typedef struct {
      tile_mem_pkg::mem_op_e   op;
      logic [`TILE_MEM_AW-1:0] addr;
      tile_mem_pkg::mem_sel_t  sel;
      tile_mem_pkg::mem_word_t wdata;
      tile_mem_pkg::mem_word_t rdata;
      int                      rise;
      int                      fall;
   } txn_t;

   logic                    clk;
   logic                    rst_n;
   logic                    req;
   tile_mem_pkg::mem_op_e   op;
   logic [`TILE_MEM_AW-1:0] addr;
   tile_mem_pkg::mem_sel_t  sel;
   tile_mem_pkg::mem_word_t wdata;
   logic                    ack;
   tile_mem_pkg::mem_word_t rdata;

   // Reference memory, one valid bit per byte lane
   tile_mem_pkg::mem_word_t model [`TILE_MEM_WORDS];
   tile_mem_pkg::mem_sel_t  valid [`TILE_MEM_WORDS];
   tile_mem_pkg::mem_word_t last_read;

   txn_t        txn_q [$];
   logic [31:0] lfsr_state;
   int          err_count;
   int          pass_count;

   tile_mem dut (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (req),
      .op    (op),
      .addr  (addr),
      .sel   (sel),
      .wdata (wdata),
      .ack   (ack),
      .rdata (rdata)
   );

   // 8 ns period
   always #4 clk = ~clk;

   // Galois LFSR, taps 32,22,2,1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // Applies one access to the model, returns the expected rdata
   function automatic tile_mem_pkg::mem_word_t ref_access(
      input tile_mem_pkg::mem_op_e   o,
      input logic [`TILE_MEM_AW-1:0] a,
      input tile_mem_pkg::mem_sel_t  s,
      input tile_mem_pkg::mem_word_t d
   );
      if (o == tile_mem_pkg::MEM_WRITE) begin
         for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
               model[a][b*8 +: 8] = d[b*8 +: 8];
               valid[a][b] = 1'b1;
            end
         end
      end else begin
         last_read = model[a];
      end
      // Writes leave rdata at the last read value
      return last_read;
   endfunction

   task automatic check_word(input string name, input tile_mem_pkg::mem_word_t got,
                             input tile_mem_pkg::mem_word_t exp);
      if (got !== exp) begin
         $display("** Error %s: got %h expected %h", name, got, exp);
         err_count++;
      end else begin
         pass_count++;
      end
   endtask

   task automatic check_latency(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("** Error %s: got %h expected %h", name, got, exp);
         err_count++;
      end else begin
         pass_count++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("** Error %s: got %h expected %h", name, got, exp);
         err_count++;
      end else begin
         pass_count++;
      end
   endtask

   // Full four-phase cycle, edges counted from the edge that samples req
   task automatic run_txn(input tile_mem_pkg::mem_op_e o, input logic [`TILE_MEM_AW-1:0] a,
                          input tile_mem_pkg::mem_sel_t s, input tile_mem_pkg::mem_word_t d);
      txn_t t;
      int   edges;
      @(negedge clk);
      op = o;
      addr = a;
      sel = s;
      wdata = d;
      req = 1'b1;
      edges = -1;
      do begin
         @(posedge clk);
         edges++;
         @(negedge clk);
      end while (!ack && edges < ACK_LIMIT);
      if (!ack) begin
         $display("ack never rose for the request at word %h", a);
         err_count++;
      end
      t.op = o;
      t.addr = a;
      t.sel = s;
      t.wdata = d;
      t.rdata = rdata;
      t.rise = edges;
      // Drop req and time the ack release
      req = 1'b0;
      edges = -1;
      do begin
         @(posedge clk);
         edges++;
         @(negedge clk);
      end while (ack && edges < ACK_LIMIT);
      if (ack) begin
         $display("ack stayed high after req dropped at word %h", a);
         err_count++;
      end
      t.fall = edges;
      txn_q.push_back(t);
   endtask

   task automatic do_write(input logic [`TILE_MEM_AW-1:0] a, input tile_mem_pkg::mem_sel_t s,
                           input tile_mem_pkg::mem_word_t d);
      run_txn(tile_mem_pkg::MEM_WRITE, a, s, d);
   endtask

   task automatic do_read(input logic [`TILE_MEM_AW-1:0] a);
      run_txn(tile_mem_pkg::MEM_READ, a, 4'h0, 32'h0);
   endtask

   // Lets the comparing process catch up with the driver
   task automatic sync_compare();
      wait (txn_q.size() == 0);
   endtask

   task automatic report_test(input string name, input int err_before);
      sync_compare();
      $display("test %s finished, %0d errors", name, err_count - err_before);
   endtask

   // Comparing process, one pass per ack
   initial begin : compare_proc
      txn_t                    t;
      tile_mem_pkg::mem_word_t exp;
      forever begin
         wait (txn_q.size() > 0);
         t = txn_q.pop_front();
         if (t.op == tile_mem_pkg::MEM_READ && valid[t.addr] != 4'hf) begin
            $display("read from word %h that was never fully written", t.addr);
            err_count++;
         end
         exp = ref_access(t.op, t.addr, t.sel, t.wdata);
         check_word("rdata", t.rdata, exp);
         check_latency("ack rise edges", t.rise, 3);
         check_latency("ack fall edges", t.fall, 1);
      end
   end

   // Ends a hung run
   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
      $display("** FAIL **");
      $finish;
   end

   initial begin : stimulus
      logic [`TILE_MEM_AW-1:0] bound_addr [8];
      tile_mem_pkg::mem_sel_t  mixed [3];
      logic [`TILE_MEM_AW-1:0] a;
      logic [1:0]              blk;
      tile_mem_pkg::mem_sel_t  s;
      int                      err_before;
      bound_addr = '{11'd0, 11'd511, 11'd512, 11'd1023, 11'd1024, 11'd1535, 11'd1536, 11'd2047};
      mixed = '{4'b0101, 4'b1010, 4'b0110};
      clk = 1'b0;
      rst_n = 1'b0;
      req = 1'b0;
      op = tile_mem_pkg::MEM_READ;
      addr = '0;
      sel = '0;
      wdata = '0;
      lfsr_state = 32'h6c58;
      err_count = 0;
      pass_count = 0;
      last_read = '0;
      for (int i = 0; i < `TILE_MEM_WORDS; i++) begin
         valid[i] = 4'h0;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // Idle outputs before any request
      err_before = err_count;
      @(negedge clk);
      check_bit("ack", ack, 1'b0);
      check_word("rdata", rdata, 32'h0);
      report_test("reset", err_before);

      // Both ends of every block
      err_before = err_count;
      foreach (bound_addr[i]) begin
         do_write(bound_addr[i], 4'hf, rand_bits(32));
      end
      foreach (bound_addr[i]) begin
         do_read(bound_addr[i]);
      end
      report_test("block boundaries", err_before);

      // Lane merges over a known word
      err_before = err_count;
      do_write(11'd100, 4'hf, 32'h1122_3344);
      do_read(11'd100);
      for (int b = 0; b < 4; b++) begin
         do_write(11'd100, 4'(1 << b), 32'hA0B0_C0D0 | (32'h0101_0101 * b));
         do_read(11'd100);
      end
      foreach (mixed[i]) begin
         do_write(11'd100, mixed[i], rand_bits(32));
         do_read(11'd100);
      end
      report_test("byte lanes", err_before);

      // Writes after a read leave rdata alone
      err_before = err_count;
      do_read(11'd512);
      do_write(11'd513, 4'hf, 32'hDEAD_BEEF);
      do_write(11'd7, 4'h3, 32'h0000_5A5A);
      do_write(11'd2046, 4'h8, 32'h7700_0000);
      report_test("rdata hold", err_before);

      // Random mix, reads only to fully written words
      // 16 words at the base of each block, so words fill up and get read back
      err_before = err_count;
      for (int i = 0; i < N_RANDOM; i++) begin
         sync_compare();
         blk = 2'(rand_bits(2));
         a = {blk, 5'd0, 4'(rand_bits(4))};
         if (rand_bits(1) && valid[a] == 4'hf) begin
            do_read(a);
         end else begin
            s = 4'(rand_bits(4));
            if (s == 4'h0) begin
               s = 4'hf;
            end
            do_write(a, s, rand_bits(32));
         end
      end
      report_test("random", err_before);

      sync_compare();
      $display("checks passed %0d, errors %0d", pass_count, err_count);
      if (err_count == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

/* src/tile_mem.sv */
// Tile-local memory top level
`timescale 1ns/100ps
`include "tile_mem_defs.svh"

module tile_mem (
   input  logic                    clk,
   input  logic                    rst_n,
   // Four-phase request
   input  logic                    req,
   input  tile_mem_pkg::mem_op_e   op,
   input  logic [`TILE_MEM_AW-1:0] addr,
   input  tile_mem_pkg::mem_sel_t  sel,
   input  tile_mem_pkg::mem_word_t wdata,
   // Response
   output logic                    ack,
   output tile_mem_pkg::mem_word_t rdata
);

   // Adapter to RAM access path
   sram_if mem_bus ();

   // Handshake and access sequencing
   sram_bus_adapter u_adapter (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (req),
      .op    (op),
      .addr  (addr),
      .sel   (sel),
      .wdata (wdata),
      .ack   (ack),
      .rdata (rdata),
      .mem   (mem_bus.ctrl)
   );

   // Storage, 8 kByte as four 2 kByte blocks
   sram_sp_banked #(
      .MEM_SIZE (`TILE_MEM_SIZE)
   ) u_ram (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (mem_bus.mem)
   );

endmodule

/* src/sram_bus_adapter.sv */
// Four-phase bus to RAM adapter
`timescale 1ns/100ps
`include "tile_mem_defs.svh"

module sram_bus_adapter (
   input  logic                    clk,
   input  logic                    rst_n,
   // Requester side
   input  logic                    req,
   input  tile_mem_pkg::mem_op_e   op,
   input  logic [`TILE_MEM_AW-1:0] addr,
   input  tile_mem_pkg::mem_sel_t  sel,
   input  tile_mem_pkg::mem_word_t wdata,
   output logic                    ack,
   output tile_mem_pkg::mem_word_t rdata,
   // RAM side
   sram_if.ctrl                    mem
);

   tile_mem_pkg::adapter_state_e state;
   tile_mem_pkg::adapter_state_e state_nxt;

   // New request accepted in idle
   // Ack still high means the last handshake has not closed
   logic start;

   assign start = (state == tile_mem_pkg::ST_IDLE) && req && !ack;

   // Next state
   always_comb begin
      state_nxt = state;
      case (state)
         tile_mem_pkg::ST_IDLE: begin
            if (start) begin
               state_nxt = tile_mem_pkg::ST_ACCESS;
            end
         end
         // RAM access happens on the edge leaving this state
         tile_mem_pkg::ST_ACCESS: begin
            state_nxt = tile_mem_pkg::ST_CAPTURE;
         end
         tile_mem_pkg::ST_CAPTURE: begin
            state_nxt = tile_mem_pkg::ST_DONE;
         end
         // Wait for the requester to drop req after ack
         tile_mem_pkg::ST_DONE: begin
            if (ack && !req) begin
               state_nxt = tile_mem_pkg::ST_IDLE;
            end
         end
         default: begin
            state_nxt = tile_mem_pkg::ST_IDLE;
         end
      endcase
   end

   // Control state
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state  <= tile_mem_pkg::ST_IDLE;
         ack    <= 1'b0;
         mem.ce <= 1'b0;
         rdata  <= '0;
      end else begin
         state <= state_nxt;
         // Strobe for exactly the ST_ACCESS cycle
         mem.ce <= start;
         // Registered, so it rises one edge after ST_DONE is entered
         // and falls one edge after req is seen low
         ack <= (state == tile_mem_pkg::ST_DONE);
         // Read data lands here, writes keep the last read value
         if ((state == tile_mem_pkg::ST_CAPTURE) && !mem.we) begin
            rdata <= mem.dout;
         end
      end
   end

   // Request fields, loaded together with the strobe
   // They stay on the interface until the next request
   always_ff @(posedge clk) begin
      if (start) begin
         mem.we   <= (op == tile_mem_pkg::MEM_WRITE);
         mem.sel  <= sel;
         mem.addr <= addr;
         mem.din  <= wdata;
      end
   end

   // Ack only ever answers a request that was still up
   a_ack_needs_req: assert property (
      @(posedge clk) disable iff (!rst_n)
      $rose(ack) |-> $past(req)
   ) else $error("sram_bus_adapter: ack rose without req");

   // One access per request
   a_ce_single: assert property (
      @(posedge clk) disable iff (!rst_n)
      mem.ce |=> !mem.ce
   ) else $error("sram_bus_adapter: ce high for two cycles");

   // Strobe register must track the FSM
   a_ce_in_access: assert property (
      @(posedge clk) disable iff (!rst_n)
      mem.ce |-> (state == tile_mem_pkg::ST_ACCESS)
   ) else $error("sram_bus_adapter: ce outside ST_ACCESS");

endmodule

/* src/sram_sp_banked.sv */
// Banked single-port RAM
`timescale 1ns/100ps

module sram_sp_banked #(
   // Memory size in bytes
   parameter int MEM_SIZE = 8192
) (
   input  logic clk,
   input  logic rst_n,
   sram_if.mem  bus
);

   // Size in words
   localparam int MEM_WORDS = MEM_SIZE / 4;

   // Word address bits inside one block
   localparam int WORD_AW = 9;
   localparam int BLOCK_WORDS = 1 << WORD_AW;

   // Block count, rounded up
   localparam int BLOCKNUM = (MEM_WORDS + BLOCK_WORDS - 1) / BLOCK_WORDS;

   // Block number width, at least one bit
   localparam int BLOCK_AW = (BLOCKNUM > 1) ? $clog2(BLOCKNUM) : 1;

   // Address split
   //   upper bits  block number
   //   lower 9     word in block
   logic [BLOCK_AW-1:0] block_addr;
   logic [WORD_AW-1:0]  word_addr;

   // Block of the last read, steers the output mux
   logic [BLOCK_AW-1:0] rd_block;

   // Per block enables and data
   logic                    blk_en   [BLOCKNUM];
   tile_mem_pkg::mem_sel_t  blk_we   [BLOCKNUM];
   tile_mem_pkg::mem_word_t blk_dout [BLOCKNUM];

   assign block_addr = BLOCK_AW'(bus.addr >> WORD_AW);
   assign word_addr  = bus.addr[WORD_AW-1:0];

   for (genvar i = 0; i < BLOCKNUM; i++) begin : g_block
      // Only the addressed block is clocked in
      assign blk_en[i] = bus.ce && (block_addr == BLOCK_AW'(i));

      // Lanes reach a block only on a write to it
      assign blk_we[i] = bus.sel & {4{bus.we && blk_en[i]}};

      bram_block u_bram (
         .clk  (clk),
         .en   (blk_en[i]),
         .we   (blk_we[i]),
         .addr (word_addr),
         .din  (bus.din),
         .dout (blk_dout[i])
      );
   end

   // Remember which block answered the last read
   // A later access with a new address leaves the mux alone
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_block <= '0;
      end else if (bus.ce && !bus.we) begin
         rd_block <= block_addr;
      end
   end

   // Output select by read block
   assign bus.dout = blk_dout[rd_block];

   // Controller may only name existing words
   a_addr_in_range: assert property (
      @(posedge clk) disable iff (!rst_n)
      bus.ce |-> (bus.addr < MEM_WORDS)
   ) else $error("sram_sp_banked: access beyond memory size");

   // A write with no lanes set is a controller bug
   a_write_has_lane: assert property (
      @(posedge clk) disable iff (!rst_n)
      (bus.ce && bus.we) |-> (bus.sel != '0)
   ) else $error("sram_sp_banked: write without byte lanes");

endmodule

/* src/bram_block.sv */
// 512 x 32 block RAM model
`timescale 1ns/100ps

module bram_block (
   input  logic                    clk,
   input  logic                    en,
   input  tile_mem_pkg::mem_sel_t  we,
   input  logic [8:0]              addr,
   input  tile_mem_pkg::mem_word_t din,
   output tile_mem_pkg::mem_word_t dout
);

   // Words in one block, 2 kByte
   localparam int DEPTH = 512;

   // Storage, no reset like the vendor primitive
   tile_mem_pkg::mem_word_t mem [DEPTH];

   // Byte-wise write with read-before-write output register
   always_ff @(posedge clk) begin
      if (en) begin
         for (int b = 0; b < 4; b++) begin
            // Only the enabled lanes change
            if (we[b]) begin
               mem[addr][b*8 +: 8] <= din[b*8 +: 8];
            end
         end
         // Old word goes out even on a write
         dout <= mem[addr];
      end
   end

   // Lane enables come from the banked wrapper
   // They must be gated by the block enable there
   a_no_write_when_idle: assert property (
      @(posedge clk) !en |-> (we == '0)
   ) else $error("bram_block: byte write while block disabled");

endmodule

/* src/sram_if.sv */
// Single-port RAM access interface
`timescale 1ns/100ps
`include "tile_mem_defs.svh"

interface sram_if;

   // Access strobe, one access per rising edge with ce high
   logic ce;

   // Write when high, read when low
   logic we;

   // Byte lanes for writes
   tile_mem_pkg::mem_sel_t sel;

   // Word address over the whole memory
   logic [`TILE_MEM_AW-1:0] addr;

   // Write data
   tile_mem_pkg::mem_word_t din;

   // Read data, valid after the access edge of a read
   tile_mem_pkg::mem_word_t dout;

   // Side that issues accesses
   modport ctrl (
      output ce,
      output we,
      output sel,
      output addr,
      output din,
      input  dout
   );

   // Side that holds the storage
   modport mem (
      input  ce,
      input  we,
      input  sel,
      input  addr,
      input  din,
      output dout
   );

endinterface

/* src/tile_mem_pkg.sv */
// Tile memory shared types
package tile_mem_pkg;

   // One data word as seen on the bus and in the RAM
   typedef logic [31:0] mem_word_t;

   // Byte lane enables
   // Lane 0 is bits 7:0, lane 3 is bits 31:24
   typedef logic [3:0] mem_sel_t;

   // Bus operation, only read and write exist
   typedef enum logic {
      MEM_READ  = 1'b0,
      MEM_WRITE = 1'b1
   } mem_op_e;

   // Adapter sequence for one request
   // ST_ACCESS  ce strobe to the RAM
   // ST_CAPTURE read data into rdata
   // ST_DONE    ack held until req drops
   typedef enum logic [1:0] {
      ST_IDLE    = 2'd0,
      ST_ACCESS  = 2'd1,
      ST_CAPTURE = 2'd2,
      ST_DONE    = 2'd3
   } adapter_state_e;

endpackage

/* src/tile_mem_defs.svh */
// Tile memory geometry
`ifndef TILE_MEM_DEFS_SVH
`define TILE_MEM_DEFS_SVH

// Total memory size in bytes
`define TILE_MEM_SIZE 8192

// Same size counted in 32-bit words
`define TILE_MEM_WORDS (`TILE_MEM_SIZE / 4)

// Word address width over the whole memory
`define TILE_MEM_AW 11

// Word address width inside one 2 kByte block
// 512 words per block
`define BRAM_WORD_AW 9

`endif
